//--- logic/renkon_pkg.sv
package renkon_pkg;

  // Data widths
  localparam int DWIDTH  = 8;                 // Pixel and weight
  localparam int RWIDTH  = 20;                // Nine 8x8 products fit
  localparam int SWIDTH  = 5;                 // Image size and coordinates
  localparam int PAWIDTH = 8;                 // APB address
  localparam int PDWIDTH = 32;                // APB data

  // Kernel and image geometry
  localparam int FIL     = 3;
  localparam int PAD     = 1;
  localparam int WINSIZE = FIL * FIL;         // Window registers
  localparam int MAX_IMG = 16;
  localparam int BUFLINE = 4;                 // Rotating line memories
  localparam int BUFSIZE = MAX_IMG + 2 * PAD; // Words per line incl. pad columns
  localparam int AWIDTH  = $clog2(BUFSIZE);

  typedef logic signed [DWIDTH-1:0] pixel_t;
  typedef logic signed [RWIDTH-1:0] result_t;
  typedef logic [AWIDTH-1:0]        addr_t;
  typedef logic [SWIDTH-1:0]        size_t;
  typedef logic [2:0]               line_sel_t;  // 0 is none, 1..4 pick a line

  // APB register map
  localparam logic [PAWIDTH-1:0] ADDR_CTRL    = 8'h00;
  localparam logic [PAWIDTH-1:0] ADDR_STATUS  = 8'h04;
  localparam logic [PAWIDTH-1:0] ADDR_PIXEL   = 8'h08;
  localparam logic [PAWIDTH-1:0] ADDR_WEIGHT0 = 8'h10;  // Nine words up to 0x30

  // Producer sequencing
  typedef enum logic [2:0] {
    IDLE,
    PAD_L,
    PIXEL,
    PAD_R,
    SWEEP,
    FLUSH
  } prod_state_t;

endpackage

//--- logic/mem_sp.sv
`timescale 1ns/1ps

module mem_sp (
  input  logic               clk,
  input  logic               mem_we,
  input  renkon_pkg::addr_t  mem_addr,
  input  renkon_pkg::pixel_t mem_wdata,
  output renkon_pkg::pixel_t mem_rdata
);

  renkon_pkg::pixel_t mem [renkon_pkg::BUFSIZE];

  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];  // Old word on a write cycle
  end

endmodule

//--- logic/renkon_linebuf_pad.sv
`timescale 1ns/1ps

module renkon_linebuf_pad (
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       buf_wcol,
  input  logic [renkon_pkg::FIL-1:0] buf_rrow,
  input  renkon_pkg::line_sel_t      buf_wsel,
  input  renkon_pkg::line_sel_t      buf_rsel,
  input  logic                       buf_we,
  input  renkon_pkg::addr_t          buf_addr,
  input  renkon_pkg::pixel_t         buf_input,
  output renkon_pkg::pixel_t         buf_output [renkon_pkg::WINSIZE]
);

  logic [renkon_pkg::BUFLINE-1:0] mem_we;
  renkon_pkg::pixel_t             mem_wdata;
  renkon_pkg::pixel_t             mem_rdata [renkon_pkg::BUFLINE];
  renkon_pkg::pixel_t             row_mux [renkon_pkg::FIL];
  renkon_pkg::pixel_t             win [renkon_pkg::WINSIZE];

  assign mem_wdata  = buf_wcol ? buf_input : '0;  // Pad columns store zero
  assign buf_output = win;

  for (genvar i = 0; i < renkon_pkg::BUFLINE; i++) begin : g_line
    assign mem_we[i] = buf_we && (buf_wsel == renkon_pkg::line_sel_t'(i + 1));

    mem_sp u_mem (
      .clk       (clk),
      .mem_we    (mem_we[i]),
      .mem_addr  (buf_addr),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata[i])
    );
  end

  // Window row i reads line (i + rotation) mod 4
  for (genvar i = 0; i < renkon_pkg::FIL; i++) begin : g_mux
    assign row_mux[i] = (buf_rsel == '0) ? '0 :
        mem_rdata[(i + int'(buf_rsel) - 1) % renkon_pkg::BUFLINE];
  end

  for (genvar i = 0; i < renkon_pkg::FIL; i++) begin : g_row
    for (genvar j = 0; j < renkon_pkg::FIL; j++) begin : g_col
      if (j == renkon_pkg::FIL - 1) begin : g_right
        always_ff @(posedge clk) begin
          if (!xrst) begin
            win[renkon_pkg::FIL*i + j] <= '0;
          end else if (buf_rrow[i]) begin
            win[renkon_pkg::FIL*i + j] <= row_mux[i];
          end else begin
            win[renkon_pkg::FIL*i + j] <= '0;  // Disabled row reads as pad
          end
        end
      end else begin : g_shift
        always_ff @(posedge clk) begin
          if (!xrst) begin
            win[renkon_pkg::FIL*i + j] <= '0;
          end else begin
            win[renkon_pkg::FIL*i + j] <= win[renkon_pkg::FIL*i + j + 1];
          end
        end
      end
    end
  end

endmodule

//--- logic/renkon_linebuf_ctrl.sv
`timescale 1ns/1ps

module renkon_linebuf_ctrl (
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       start,
  input  renkon_pkg::size_t          img_size,
  input  logic                       pix_req,
  input  renkon_pkg::pixel_t         pix_data,
  output logic                       pix_ack,
  output logic                       busy,
  output logic                       buf_we,
  output renkon_pkg::line_sel_t      buf_wsel,
  output logic                       buf_wcol,
  output renkon_pkg::addr_t          buf_addr,
  output renkon_pkg::pixel_t         buf_input,
  output logic [renkon_pkg::FIL-1:0] buf_rrow,
  output renkon_pkg::line_sel_t      buf_rsel,
  output logic                       win_valid,
  output renkon_pkg::size_t          win_row,
  output renkon_pkg::size_t          win_col
);

  renkon_pkg::prod_state_t    state;
  renkon_pkg::addr_t          col;        // Next pixel column, 1..img_size
  renkon_pkg::addr_t          sw_addr;    // Sweep read address
  renkon_pkg::addr_t          last_addr;  // Right pad column
  renkon_pkg::size_t          in_row;     // Completed input rows
  renkon_pkg::size_t          out_row;    // Row being swept
  logic [1:0]                 wline;      // Line taking the current input row
  logic [1:0]                 top_line;   // Line holding row out_row-1
  logic                       sweeping;
  logic                       issue_v;
  logic [renkon_pkg::FIL-1:0] row_en;
  logic [3:0]                 vld_pipe;   // Bit 1 is the window, bit 3 the result
  renkon_pkg::size_t          row_d [2];
  renkon_pkg::size_t          col_d [2];

  assign last_addr = renkon_pkg::addr_t'(img_size) + renkon_pkg::addr_t'(renkon_pkg::PAD);
  assign sweeping  = (state == renkon_pkg::SWEEP) || (state == renkon_pkg::FLUSH);
  assign issue_v   = sweeping && (sw_addr >= renkon_pkg::addr_t'(2 * renkon_pkg::PAD));

  // Bottom row is below the image during flush, top row above it on row 0
  assign row_en = {state != renkon_pkg::FLUSH, 1'b1, out_row != '0};

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state    <= renkon_pkg::IDLE;
      col      <= renkon_pkg::addr_t'(1);
      sw_addr  <= '0;
      in_row   <= '0;
      out_row  <= '0;
      wline    <= '0;
      top_line <= 2'd3;
    end else if (start) begin
      state    <= renkon_pkg::PAD_L;
      col      <= renkon_pkg::addr_t'(1);
      sw_addr  <= '0;
      in_row   <= '0;
      out_row  <= '0;
      wline    <= '0;
      top_line <= 2'd3;  // Row -1 sits before line 0
    end else begin
      case (state)
        renkon_pkg::PAD_L: state <= renkon_pkg::PIXEL;
        renkon_pkg::PIXEL: begin
          if (pix_ack) begin
            if (col == renkon_pkg::addr_t'(img_size)) begin
              col   <= renkon_pkg::addr_t'(1);
              state <= renkon_pkg::PAD_R;
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        renkon_pkg::PAD_R: begin
          in_row <= in_row + 1'b1;
          wline  <= wline + 1'b1;
          if (in_row != '0) begin
            state <= renkon_pkg::SWEEP;  // Rows r-1..r+1 are now stored
          end else begin
            state <= renkon_pkg::PAD_L;
          end
        end
        renkon_pkg::SWEEP, renkon_pkg::FLUSH: begin
          if (sw_addr == last_addr) begin
            sw_addr  <= '0;
            out_row  <= out_row + 1'b1;
            top_line <= top_line + 1'b1;
            if (state == renkon_pkg::FLUSH) begin
              state <= renkon_pkg::IDLE;
            end else if (in_row == img_size) begin
              state <= renkon_pkg::FLUSH;
            end else begin
              state <= renkon_pkg::PAD_L;
            end
          end else begin
            sw_addr <= sw_addr + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Pixels outside an image are acked and dropped
  always_ff @(posedge clk) begin
    if (!xrst) begin
      pix_ack <= 1'b0;
    end else begin
      pix_ack <= pix_req && !pix_ack &&
                 ((state == renkon_pkg::PIXEL) || (state == renkon_pkg::IDLE));
    end
  end

  always_ff @(posedge clk) begin
    if (pix_req && !pix_ack) begin
      buf_input <= pix_data;
    end
  end

  always_comb begin
    buf_we   = 1'b0;
    buf_wcol = 1'b0;
    buf_addr = sw_addr;
    case (state)
      renkon_pkg::PAD_L: begin
        buf_we   = 1'b1;
        buf_addr = '0;
      end
      renkon_pkg::PAD_R: begin
        buf_we   = 1'b1;
        buf_addr = last_addr;
      end
      renkon_pkg::PIXEL: begin
        if (pix_ack) begin
          buf_we   = 1'b1;
          buf_wcol = 1'b1;
          buf_addr = col;
        end
      end
      default: ;
    endcase
  end

  assign buf_wsel = renkon_pkg::line_sel_t'({1'b0, wline}) + 3'd1;

  // Row selects line up with the memory read data
  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_rrow <= '0;
      buf_rsel <= '0;
      vld_pipe <= '0;
    end else begin
      buf_rrow <= sweeping ? row_en : '0;
      buf_rsel <= sweeping ? renkon_pkg::line_sel_t'({1'b0, top_line}) + 3'd1 : '0;
      vld_pipe <= {vld_pipe[2:0], issue_v};
    end
  end

  always_ff @(posedge clk) begin
    row_d[0] <= out_row;
    row_d[1] <= row_d[0];
    col_d[0] <= renkon_pkg::size_t'(sw_addr - renkon_pkg::addr_t'(2 * renkon_pkg::PAD));
    col_d[1] <= col_d[0];
  end

  assign win_valid = vld_pipe[1];
  assign win_row   = row_d[1];
  assign win_col   = col_d[1];
  assign busy      = (state != renkon_pkg::IDLE) || (vld_pipe != '0);

endmodule

//--- logic/renkon_conv_mac.sv
`timescale 1ns/1ps

module renkon_conv_mac (
  input  logic                clk,
  input  logic                xrst,
  input  logic                win_valid,
  input  renkon_pkg::size_t   win_row,
  input  renkon_pkg::size_t   win_col,
  input  renkon_pkg::pixel_t  window [renkon_pkg::WINSIZE],
  input  renkon_pkg::pixel_t  weight [renkon_pkg::WINSIZE],
  input  renkon_pkg::size_t   img_size,
  output logic                out_valid,
  output renkon_pkg::result_t out_data,
  output renkon_pkg::size_t   out_row,
  output renkon_pkg::size_t   out_col,
  output logic                done_pulse
);

  renkon_pkg::result_t prod [renkon_pkg::WINSIZE];
  renkon_pkg::result_t sum;
  renkon_pkg::size_t   row1;
  renkon_pkg::size_t   col1;
  renkon_pkg::size_t   last;
  logic                v1;

  // Stage one products
  always_ff @(posedge clk) begin
    for (int k = 0; k < renkon_pkg::WINSIZE; k++) begin
      prod[k] <= renkon_pkg::result_t'(window[k]) * renkon_pkg::result_t'(weight[k]);
    end
    row1 <= win_row;
    col1 <= win_col;
  end

  always_comb begin
    sum = '0;
    for (int k = 0; k < renkon_pkg::WINSIZE; k++) begin
      sum = sum + prod[k];
    end
  end

  // Stage two sum
  always_ff @(posedge clk) begin
    out_data <= sum;
    out_row  <= row1;
    out_col  <= col1;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      v1        <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      v1        <= win_valid;
      out_valid <= v1;
    end
  end

  assign last       = img_size - 1'b1;
  assign done_pulse = out_valid && (out_row == last) && (out_col == last);  // Bottom right

endmodule

//--- logic/renkon_apb_regs.sv
`timescale 1ns/1ps

module renkon_apb_regs (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [renkon_pkg::PAWIDTH-1:0] paddr,
  input  logic [renkon_pkg::PDWIDTH-1:0] pwdata,
  output logic [renkon_pkg::PDWIDTH-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  output renkon_pkg::size_t              img_size,
  output renkon_pkg::pixel_t             weight [renkon_pkg::WINSIZE],
  output logic                           start,
  output logic                           pix_req,
  output renkon_pkg::pixel_t             pix_data,
  input  logic                           pix_ack,
  input  logic                           busy,
  input  logic                           done_pulse
);

  logic                           access;
  logic                           is_ctrl;
  logic                           is_status;
  logic                           is_pixel;
  logic                           is_weight;
  logic                           in_map;
  logic                           wr_done;
  logic                           done;
  logic [renkon_pkg::PAWIDTH-1:0] wofs;
  logic [3:0]                     widx;

  assign access    = psel && penable;
  assign is_ctrl   = (paddr == renkon_pkg::ADDR_CTRL);
  assign is_status = (paddr == renkon_pkg::ADDR_STATUS);
  assign is_pixel  = (paddr == renkon_pkg::ADDR_PIXEL);
  assign wofs      = paddr - renkon_pkg::ADDR_WEIGHT0;
  assign widx      = wofs[5:2];
  assign is_weight = (paddr >= renkon_pkg::ADDR_WEIGHT0) && (wofs[1:0] == 2'b00) &&
                     (wofs <= 8'(4 * (renkon_pkg::WINSIZE - 1)));
  assign in_map    = is_ctrl || is_status || is_pixel || is_weight;

  // Pixel writes wait for the producer
  assign pix_req  = access && pwrite && is_pixel;
  assign pix_data = pwdata[renkon_pkg::DWIDTH-1:0];
  assign pready   = !pix_req || pix_ack;
  assign pslverr  = access && !in_map;
  assign wr_done  = access && pwrite && pready;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_size <= '0;
      start    <= 1'b0;
      done     <= 1'b0;
      for (int k = 0; k < renkon_pkg::WINSIZE; k++) begin
        weight[k] <= '0;
      end
    end else begin
      start <= wr_done && is_ctrl;
      if (wr_done && is_ctrl) begin
        img_size <= pwdata[renkon_pkg::SWIDTH-1:0];
      end
      if (wr_done && is_weight) begin
        weight[widx] <= pwdata[renkon_pkg::DWIDTH-1:0];
      end
      if (wr_done && is_ctrl) begin
        done <= 1'b0;  // New image clears done
      end else if (done_pulse) begin
        done <= 1'b1;
      end
    end
  end

  always_comb begin
    prdata = '0;
    if (psel && !pwrite) begin
      if (is_ctrl) begin
        prdata[renkon_pkg::SWIDTH-1:0] = img_size;
      end else if (is_status) begin
        prdata[1:0] = {done, busy};
      end else if (is_weight) begin
        prdata[renkon_pkg::DWIDTH-1:0] = weight[widx];
      end
    end
  end

endmodule

//--- logic/renkon_conv_top.sv
`timescale 1ns/1ps

module renkon_conv_top (
  input  logic                           clk,
  input  logic                           xrst,
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [renkon_pkg::PAWIDTH-1:0] paddr,
  input  logic [renkon_pkg::PDWIDTH-1:0] pwdata,
  output logic [renkon_pkg::PDWIDTH-1:0] prdata,
  output logic                           pready,
  output logic                           pslverr,
  output logic                           out_valid,
  output renkon_pkg::result_t            out_data,
  output renkon_pkg::size_t              out_row,
  output renkon_pkg::size_t              out_col
);

  renkon_pkg::size_t          img_size;
  renkon_pkg::pixel_t         weight [renkon_pkg::WINSIZE];
  logic                       start;
  logic                       pix_req;
  renkon_pkg::pixel_t         pix_data;
  logic                       pix_ack;
  logic                       busy;
  logic                       done_pulse;
  logic                       buf_we;
  renkon_pkg::line_sel_t      buf_wsel;
  logic                       buf_wcol;
  renkon_pkg::addr_t          buf_addr;
  renkon_pkg::pixel_t         buf_input;
  logic [renkon_pkg::FIL-1:0] buf_rrow;
  renkon_pkg::line_sel_t      buf_rsel;
  renkon_pkg::pixel_t         buf_output [renkon_pkg::WINSIZE];
  logic                       win_valid;
  renkon_pkg::size_t          win_row;
  renkon_pkg::size_t          win_col;

  renkon_apb_regs u_regs (
    .clk        (clk),
    .xrst       (xrst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .img_size   (img_size),
    .weight     (weight),
    .start      (start),
    .pix_req    (pix_req),
    .pix_data   (pix_data),
    .pix_ack    (pix_ack),
    .busy       (busy),
    .done_pulse (done_pulse)
  );

  renkon_linebuf_ctrl u_ctrl (
    .clk       (clk),
    .xrst      (xrst),
    .start     (start),
    .img_size  (img_size),
    .pix_req   (pix_req),
    .pix_data  (pix_data),
    .pix_ack   (pix_ack),
    .busy      (busy),
    .buf_we    (buf_we),
    .buf_wsel  (buf_wsel),
    .buf_wcol  (buf_wcol),
    .buf_addr  (buf_addr),
    .buf_input (buf_input),
    .buf_rrow  (buf_rrow),
    .buf_rsel  (buf_rsel),
    .win_valid (win_valid),
    .win_row   (win_row),
    .win_col   (win_col)
  );

  renkon_linebuf_pad u_buf (
    .clk        (clk),
    .xrst       (xrst),
    .buf_wcol   (buf_wcol),
    .buf_rrow   (buf_rrow),
    .buf_wsel   (buf_wsel),
    .buf_rsel   (buf_rsel),
    .buf_we     (buf_we),
    .buf_addr   (buf_addr),
    .buf_input  (buf_input),
    .buf_output (buf_output)
  );

  renkon_conv_mac u_mac (
    .clk        (clk),
    .xrst       (xrst),
    .win_valid  (win_valid),
    .win_row    (win_row),
    .win_col    (win_col),
    .window     (buf_output),
    .weight     (weight),
    .img_size   (img_size),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_row    (out_row),
    .out_col    (out_col),
    .done_pulse (done_pulse)
  );

endmodule

//--- tb/renkon_conv_checker.sv
`timescale 1ns/1ps

module renkon_conv_checker (
  input logic clk,
  input logic xrst,
  input logic psel,
  input logic penable,
  input logic pready,
  input logic pslverr,
  input logic out_valid,
  input logic busy
);

  logic [6:0] wait_cnt;  // Wait states of the current transfer

  always_ff @(posedge clk) begin
    if (!xrst) begin
      wait_cnt <= '0;
    end else if (psel && penable && !pready) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  a_reset_stream: assert property (@(posedge clk) !xrst |=> !out_valid)
    else $error("out_valid high in the first cycle after reset");

  a_pixel_wait: assert property (@(posedge clk) disable iff (!xrst)
      wait_cnt <= 2 * renkon_pkg::MAX_IMG + 8)
    else $error("Pixel write held in wait states too long");

  a_slverr_ready: assert property (@(posedge clk) disable iff (!xrst) pslverr |-> pready)
    else $error("pslverr high without pready");

  a_valid_busy: assert property (@(posedge clk) disable iff (!xrst) out_valid |-> busy)
    else $error("out_valid high while the engine is idle");

endmodule

//--- tb/renkon_conv_tb.sv
`timescale 1ns/1ps

module renkon_conv_tb;

  logic                clk = 1'b0;
  logic                xrst;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [7:0]          paddr;
  logic [31:0]         pwdata;
  logic [31:0]         prdata;
  logic                pready;
  logic                pslverr;
  logic                out_valid;
  renkon_pkg::result_t out_data;
  renkon_pkg::size_t   out_row;
  renkon_pkg::size_t   out_col;

  integer      seed;
  int          errors;
  int          mark;
  int          tests_run;
  int          tests_failed;
  int          size;
  logic [31:0] rdata;
  logic        rerr;
  int          img [renkon_pkg::MAX_IMG][renkon_pkg::MAX_IMG];
  int          wts [renkon_pkg::WINSIZE];
  int          data_q [$];
  int          row_q [$];
  int          col_q [$];
  time         time_q [$];

  renkon_conv_top DUT (
    .clk       (clk),
    .xrst      (xrst),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_row   (out_row),
    .out_col   (out_col)
  );

  bind renkon_conv_top renkon_conv_checker u_checker (
    .clk       (clk),
    .xrst      (xrst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .out_valid (out_valid),
    .busy      (busy)
  );

  always #20 clk = ~clk;  // 40 ns period

  // Result stream collector
  always @(posedge clk) begin
    if (xrst && out_valid) begin
      data_q.push_back(int'(out_data));
      row_q.push_back(int'(out_row));
      col_q.push_back(int'(out_col));
      time_q.push_back($time);
    end
  end

  function automatic int rand_byte();
    logic [31:0] r;
    r = $random(seed);
    return int'($signed(r[7:0]));
  endfunction

  function automatic int extreme_byte();
    logic [31:0] r;
    r = $random(seed);
    return r[0] ? 127 : -128;
  endfunction

  // Zero padded 3x3 correlation with weight 3*i+j at window row i and column j
  function automatic int model_pixel(input int r, input int c, input int n);
    int acc;
    int y;
    int x;
    acc = 0;
    for (int i = 0; i < renkon_pkg::FIL; i++) begin
      for (int j = 0; j < renkon_pkg::FIL; j++) begin
        y = r + i - renkon_pkg::PAD;
        x = c + j - renkon_pkg::PAD;
        if (y >= 0 && y < n && x >= 0 && x < n) begin
          acc += wts[renkon_pkg::FIL * i + j] * img[y][x];
        end
      end
    end
    return acc;
  endfunction

  task automatic report_mismatch(input time t, input string name, input int got,
                                 input int exp);
    $display("Mismatch at time %0t: %s = %0d, expected %0d", t, name, got, exp);
    errors++;
  endtask

  // Starts and ends on a falling edge
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            output logic [31:0] rd, output logic err);
    int cnt;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    cnt = 0;
    #1;
    while (!pready && cnt < 4 * renkon_pkg::MAX_IMG) begin
      @(negedge clk);
      #1;
      cnt++;
    end
    if (!pready) begin
      $display("Timeout: no pready for access to address 0x%02h", addr);
      errors++;
    end
    rd  = prdata;
    err = pslverr;
    @(negedge clk);  // Transfer completed on the rising edge before
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    apb_access(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rd, output logic err);
    apb_access(1'b0, addr, 32'h0, rd, err);
  endtask

  task automatic configure_image(input int n, input bit extreme);
    for (int k = 0; k < renkon_pkg::WINSIZE; k++) begin
      wts[k] = extreme ? extreme_byte() : rand_byte();
      apb_write(renkon_pkg::ADDR_WEIGHT0 + 8'(4 * k), {24'h0, 8'(wts[k])}, rerr);
    end
    for (int y = 0; y < n; y++) begin
      for (int x = 0; x < n; x++) begin
        img[y][x] = extreme ? extreme_byte() : rand_byte();
      end
    end
    data_q.delete();
    row_q.delete();
    col_q.delete();
    time_q.delete();
    apb_write(renkon_pkg::ADDR_CTRL, 32'(n), rerr);
  endtask

  task automatic send_pixels(input int n, input int count);
    for (int i = 0; i < count; i++) begin
      apb_write(renkon_pkg::ADDR_PIXEL, {24'h0, 8'(img[i / n][i % n])}, rerr);
    end
  endtask

  task automatic wait_idle();
    int polls;
    polls = 0;
    rdata = 32'h1;
    while (rdata[0] && polls < 200) begin
      apb_read(renkon_pkg::ADDR_STATUS, rdata, rerr);
      polls++;
    end
    if (rdata[0]) begin
      $display("Timeout: engine still busy after %0d status reads", polls);
      errors++;
    end
  endtask

  task automatic check_results(input int n);
    int exp;
    if (data_q.size() != n * n) begin
      $display("Wrong result count: %0d results for a %0dx%0d image", data_q.size(), n, n);
      errors++;
    end
    for (int i = 0; i < data_q.size() && i < n * n; i++) begin
      exp = model_pixel(i / n, i % n, n);
      if (row_q[i] != i / n) begin
        report_mismatch(time_q[i], "out_row", row_q[i], i / n);
      end
      if (col_q[i] != i % n) begin
        report_mismatch(time_q[i], "out_col", col_q[i], i % n);
      end
      if (data_q[i] != exp) begin
        report_mismatch(time_q[i], "out_data", data_q[i], exp);
      end
    end
  endtask

  task automatic run_image(input int n, input bit extreme);
    configure_image(n, extreme);
    send_pixels(n, n * n);
    wait_idle();
    check_results(n);
    apb_read(renkon_pkg::ADDR_STATUS, rdata, rerr);
    if (!rdata[1]) begin
      $display("STATUS done flag not set after the last result");
      errors++;
    end
  endtask

  task automatic close_test(input string what);
    tests_run++;
    if (errors != mark) begin
      tests_failed++;
      $display("Test %0d, %s: %0d error(s)", tests_run, what, errors - mark);
    end else begin
      $display("Test %0d, %s: ok", tests_run, what);
    end
    mark = errors;
  endtask

  initial begin
    xrst         = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    seed         = 32'h1cb8_5e9e;
    errors       = 0;
    mark         = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (16) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);

    // Register map with the idle status first
    apb_read(renkon_pkg::ADDR_STATUS, rdata, rerr);
    if (rdata != 32'h0) begin
      report_mismatch($time, "prdata(STATUS)", int'(rdata), 0);
    end
    for (int k = 0; k < renkon_pkg::WINSIZE; k++) begin
      wts[k] = rand_byte();
      apb_write(renkon_pkg::ADDR_WEIGHT0 + 8'(4 * k), {24'h0, 8'(wts[k])}, rerr);
    end
    size = 3 + ({$random(seed)} % 14);
    apb_write(renkon_pkg::ADDR_CTRL, 32'(size), rerr);
    for (int k = 0; k < renkon_pkg::WINSIZE; k++) begin
      apb_read(renkon_pkg::ADDR_WEIGHT0 + 8'(4 * k), rdata, rerr);
      if (rdata != {24'h0, 8'(wts[k])}) begin
        report_mismatch($time, "prdata(WEIGHT)", int'(rdata), int'({24'h0, 8'(wts[k])}));
      end
    end
    apb_read(renkon_pkg::ADDR_CTRL, rdata, rerr);
    if (rdata != 32'(size)) begin
      report_mismatch($time, "prdata(CTRL)", int'(rdata), size);
    end
    apb_read(8'h40, rdata, rerr);
    if (!rerr) begin
      $display("No pslverr on a read outside the register map");
      errors++;
    end
    if (rdata != 32'h0) begin
      report_mismatch($time, "prdata(0x40)", int'(rdata), 0);
    end
    apb_write(8'h34, 32'h55, rerr);
    if (!rerr) begin
      $display("No pslverr on a write outside the register map");
      errors++;
    end
    close_test("register access");

    run_image(4, 1'b0);
    close_test("4x4 random image");

    run_image(renkon_pkg::MAX_IMG, 1'b1);
    close_test("16x16 extreme image");

    run_image(7, 1'b0);
    close_test("7x7 image after size change");

    // Done stays set until the next CTRL write
    apb_read(renkon_pkg::ADDR_STATUS, rdata, rerr);
    if (rdata[1:0] != 2'b10) begin
      report_mismatch($time, "prdata(STATUS)", int'(rdata[1:0]), 2);
    end
    apb_write(renkon_pkg::ADDR_CTRL, 32'd7, rerr);
    apb_read(renkon_pkg::ADDR_STATUS, rdata, rerr);
    if (rdata[1:0] != 2'b01) begin
      report_mismatch($time, "prdata(STATUS)", int'(rdata[1:0]), 1);
    end
    close_test("status done and busy");

    // Partial image with the first output row already swept
    configure_image(6, 1'b0);
    send_pixels(6, 20);
    xrst = 1'b0;
    data_q.delete();
    row_q.delete();
    col_q.delete();
    time_q.delete();
    repeat (16) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);
    send_pixels(6, 16);          // Rest of the image goes to an idle engine
    repeat (40) @(negedge clk);  // Quiet window after reset
    if (data_q.size() != 0) begin
      $display("Result appeared after a reset in the middle of an image");
      errors++;
    end
    run_image(5, 1'b0);
    close_test("reset in the middle of an image");

    $display("Tests run: %0d, failing: %0d, errors: %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- verilog.f
logic/renkon_pkg.sv
logic/mem_sp.sv
logic/renkon_linebuf_pad.sv
logic/renkon_linebuf_ctrl.sv
logic/renkon_conv_mac.sv
logic/renkon_apb_regs.sv
logic/renkon_conv_top.sv
tb/renkon_conv_checker.sv
tb/renkon_conv_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Compile and run the convolution engine testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module renkon_conv_tb \
  -o renkon_conv_sim

./obj_dir/renkon_conv_sim | tee sim.log

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  echo "Simulation reported failure, see sim.log"
  exit 1
fi

echo "Simulation finished without failure"
